// File: heap_consts.svh
/*
  Array heap sizes: widths of array numbers, element indices and data,
  plus the derived pool size, array length and size-field width
*/
`ifndef HEAP_CONSTS_SVH
`define HEAP_CONSTS_SVH

// --------------------
// Base widths
`define HEAP_ADDR_BITS 2                           // Bits in an array number
`define HEAP_INDEX_BITS 2                          // Bits in an element index
`define HEAP_DATA_BITS 12                          // Bits in an element

// --------------------
// Derived sizes
`define HEAP_ARRAYS (1 << `HEAP_ADDR_BITS)         // Arrays in the pool
`define HEAP_ARRAY_LENGTH (1 << `HEAP_INDEX_BITS)  // Elements per array
`define HEAP_SIZE_BITS (`HEAP_INDEX_BITS + 1)      // Holds a size of a full array

`endif

// File: heapOpsPkg.sv
/*
  Request opcodes and response status codes of the heap
*/
package heapOpsPkg;

  typedef enum logic [3:0] {
    opClear   = 4'd0,   // Drop every array
    opAlloc   = 4'd1,
    opFree    = 4'd2,
    opWrite   = 4'd3,
    opRead    = 4'd4,
    opSize    = 4'd5,
    opPush    = 4'd6,
    opPop     = 4'd7,
    opResize  = 4'd8,
    opIndex   = 4'd9,   // One plus last matching position
    opLess    = 4'd10,
    opGreater = 4'd11
  } heapOp;

  typedef enum logic [2:0] {
    statusOk           = 3'd0,
    statusNotAllocated = 3'd1,
    statusOutOfBounds  = 3'd2,
    statusFull         = 3'd3,
    statusEmpty        = 3'd4,
    statusOutOfMemory  = 3'd5,
    statusTooLarge     = 3'd6
  } heapStatus;

endpackage

// File: heapCtrlPkg.sv
/*
  State encodings of the request controller and the search scanner
*/
package heapCtrlPkg;

  typedef enum logic [1:0] {
    ctrlIdle    = 2'd0,   // Waiting for a request
    ctrlExec    = 2'd1,   // Units started
    ctrlScan    = 2'd2,   // Waiting on the search
    ctrlRespond = 2'd3    // Response held for the client
  } ctrlState;

  typedef enum logic {
    scanIdle = 1'b0,
    scanBusy = 1'b1
  } scanState;

endpackage

// File: heapAllocator.sv
/*
  Array allocator: allocation flags, stack of freed array numbers
  and the counter of arrays never handed out
*/
`timescale 1ns/1ps
`include "heap_consts.svh"

module heapAllocator (
  input  logic                       clock,
  input  logic                       resetN,
  input  logic                       allocStart,
  input  logic                       freeStart,
  input  logic                       clearStart,
  input  logic [`HEAP_ADDR_BITS-1:0] lookupArray,   // Array checked or freed
  output logic                       arrayLive,
  output logic [`HEAP_ADDR_BITS-1:0] newArray,
  output logic                       allocOk
);

  logic [`HEAP_ARRAYS-1:0]     allocated;             // One flag per array
  logic [`HEAP_ADDR_BITS-1:0]  freeStack [`HEAP_ARRAYS];
  logic [`HEAP_ADDR_BITS:0]    freeTop;               // Entries on the stack
  logic [`HEAP_ADDR_BITS:0]    topBelow;
  logic [`HEAP_ADDR_BITS:0]    nextNew;               // MSB set when pool used up
  logic                        haveFreed;

  assign haveFreed = (freeTop != '0);
  assign topBelow  = freeTop - 1'b1;
  assign arrayLive = allocated[lookupArray];

  // Freed arrays are reused first, LIFO
  assign newArray = haveFreed ? freeStack[topBelow[`HEAP_ADDR_BITS-1:0]]
                              : nextNew[`HEAP_ADDR_BITS-1:0];
  assign allocOk  = haveFreed || !nextNew[`HEAP_ADDR_BITS];

  // --------------------
  // Bookkeeping
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated <= '0;
      freeTop   <= '0;
      nextNew   <= '0;
    end else if (clearStart) begin
      allocated <= '0;                               // Whole pool back to unused
      freeTop   <= '0;
      nextNew   <= '0;
    end else if (allocStart && allocOk) begin
      allocated[newArray] <= 1'b1;
      if (haveFreed) begin
        freeTop <= topBelow;                         // Pop
      end else begin
        nextNew <= nextNew + 1'b1;
      end
    end else if (freeStart) begin
      allocated[lookupArray] <= 1'b0;
      freeTop                <= freeTop + 1'b1;      // Push
    end
  end

  always_ff @(posedge clock) begin
    if (freeStart) begin
      freeStack[freeTop[`HEAP_ADDR_BITS-1:0]] <= lookupArray;
    end
  end

endmodule

// File: heapStore.sv
/*
  Element storage: array memory, per-array sizes, the element access
  rules and a combinational read port for the search unit
*/
`timescale 1ns/1ps
`include "heap_consts.svh"

module heapStore import heapOpsPkg::*; (
  input  logic                        clock,
  input  logic                        resetN,
  input  logic                        storeStart,
  input  heapOp                       storeOp,
  input  logic [`HEAP_ADDR_BITS-1:0]  storeArray,
  input  logic [`HEAP_INDEX_BITS-1:0] storeIndex,
  input  logic [`HEAP_DATA_BITS-1:0]  storeData,
  output logic [`HEAP_DATA_BITS-1:0]  storeResult,
  output heapStatus                   storeStatus,
  input  logic [`HEAP_ADDR_BITS-1:0]  scanArray,
  input  logic [`HEAP_INDEX_BITS-1:0] scanIndex,
  output logic [`HEAP_DATA_BITS-1:0]  scanElement,
  output logic [`HEAP_SIZE_BITS-1:0]  scanSize
);

  logic [`HEAP_DATA_BITS-1:0]  mem [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];
  logic [`HEAP_SIZE_BITS-1:0]  sizes [`HEAP_ARRAYS];

  logic [`HEAP_SIZE_BITS-1:0]  curSize;
  logic [`HEAP_SIZE_BITS-1:0]  lastIndex;         // Size minus one, for pop
  logic [`HEAP_SIZE_BITS-1:0]  indexPlusOne;
  logic [`HEAP_INDEX_BITS-1:0] readIndex;
  logic [`HEAP_DATA_BITS-1:0]  readElement;
  logic                        memWrite;
  logic [`HEAP_INDEX_BITS-1:0] memIndex;
  logic                        sizeWrite;
  logic [`HEAP_SIZE_BITS-1:0]  sizeNext;
  logic [`HEAP_DATA_BITS-1:0]  resultNext;
  heapStatus                   statusNext;

  assign curSize      = sizes[storeArray];
  assign lastIndex    = curSize - 1'b1;
  assign indexPlusOne = {1'b0, storeIndex} + 1'b1;
  assign readIndex    = (storeOp == opPop) ? lastIndex[`HEAP_INDEX_BITS-1:0] : storeIndex;
  assign readElement  = mem[storeArray][readIndex];

  // Second read port
  assign scanElement = mem[scanArray][scanIndex];
  assign scanSize    = sizes[scanArray];

  // --------------------
  // Operation rules
  always_comb begin
    memWrite   = 1'b0;
    memIndex   = storeIndex;
    sizeWrite  = 1'b0;
    sizeNext   = curSize;
    resultNext = '0;
    statusNext = statusOk;
    case (storeOp)
      opAlloc: begin                                // Fresh array starts empty
        sizeWrite = 1'b1;
        sizeNext  = '0;
      end
      opWrite: begin
        memWrite   = 1'b1;
        resultNext = storeData;
        if (indexPlusOne > curSize) begin           // Grow to cover the index
          sizeWrite = 1'b1;
          sizeNext  = indexPlusOne;
        end
      end
      opRead: begin
        if ({1'b0, storeIndex} < curSize) resultNext = readElement;
        else statusNext = statusOutOfBounds;
      end
      opSize: resultNext = {{(`HEAP_DATA_BITS - `HEAP_SIZE_BITS){1'b0}}, curSize};
      opPush: begin
        if (curSize < `HEAP_ARRAY_LENGTH) begin
          memWrite   = 1'b1;
          memIndex   = curSize[`HEAP_INDEX_BITS-1:0];
          sizeWrite  = 1'b1;
          sizeNext   = curSize + 1'b1;
          resultNext = storeData;
        end else begin
          statusNext = statusFull;
        end
      end
      opPop: begin
        if (curSize != '0) begin
          sizeWrite  = 1'b1;
          sizeNext   = lastIndex;
          resultNext = readElement;
        end else begin
          statusNext = statusEmpty;
        end
      end
      opResize: begin
        if (storeData <= `HEAP_ARRAY_LENGTH) begin
          sizeWrite  = 1'b1;
          sizeNext   = storeData[`HEAP_SIZE_BITS-1:0];
          resultNext = storeData;
        end else begin
          statusNext = statusTooLarge;
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clock) begin
    if (storeStart && memWrite) mem[storeArray][memIndex] <= storeData;
    if (storeStart) begin
      storeResult <= resultNext;                    // Held until the next start
      storeStatus <= statusNext;
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      sizes <= '{default: '0};
    end else if (storeStart && sizeWrite) begin
      sizes[storeArray] <= sizeNext;
    end
  end

endmodule

// File: heapSearch.sv
/*
  Search unit: walks every position of one array through the store's
  scan port, for the index, less and greater requests
*/
`timescale 1ns/1ps
`include "heap_consts.svh"

module heapSearch import heapOpsPkg::*, heapCtrlPkg::*; (
  input  logic                        clock,
  input  logic                        resetN,
  input  logic                        searchStart,
  input  heapOp                       searchOp,
  input  logic [`HEAP_ADDR_BITS-1:0]  searchArray,
  input  logic [`HEAP_DATA_BITS-1:0]  searchKey,
  output logic [`HEAP_ADDR_BITS-1:0]  scanArray,
  output logic [`HEAP_INDEX_BITS-1:0] scanIndex,
  input  logic [`HEAP_DATA_BITS-1:0]  scanElement,
  input  logic [`HEAP_SIZE_BITS-1:0]  scanSize,
  output logic                        searchDone,
  output logic [`HEAP_DATA_BITS-1:0]  searchResult
);

  scanState                    state;
  heapOp                       op;
  logic [`HEAP_ADDR_BITS-1:0]  arrayReg;
  logic [`HEAP_DATA_BITS-1:0]  key;
  logic [`HEAP_INDEX_BITS-1:0] pos;
  logic [`HEAP_SIZE_BITS-1:0]  acc;
  logic [`HEAP_SIZE_BITS-1:0]  accNext;
  logic                        inRange;
  logic                        lastPos;

  assign scanArray = arrayReg;
  assign scanIndex = pos;
  assign inRange   = ({1'b0, pos} < scanSize);     // Ignore slots past the size
  assign lastPos   = &pos;

  always_comb begin
    accNext = acc;
    case (op)
      opIndex:   if (inRange && scanElement == key) accNext = {1'b0, pos} + 1'b1;
      opLess:    if (inRange && scanElement < key) accNext = acc + 1'b1;
      opGreater: if (inRange && scanElement > key) accNext = acc + 1'b1;
      default: ;
    endcase
  end

  // --------------------
  // Scan sequencing
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state      <= scanIdle;
      pos        <= '0;
      acc        <= '0;
      searchDone <= 1'b0;
    end else begin
      searchDone <= 1'b0;
      case (state)
        scanIdle: begin
          if (searchStart) begin
            state <= scanBusy;
            pos   <= '0;
            acc   <= '0;
          end
        end
        scanBusy: begin
          acc <= accNext;
          pos <= pos + 1'b1;                       // Wraps back to zero at the end
          if (lastPos) begin
            state      <= scanIdle;
            searchDone <= 1'b1;
          end
        end
        default: state <= scanIdle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (searchStart && state == scanIdle) begin
      op       <= searchOp;
      arrayReg <= searchArray;
      key      <= searchKey;
    end
    if (state == scanBusy && lastPos) begin
      searchResult <= {{(`HEAP_DATA_BITS - `HEAP_SIZE_BITS){1'b0}}, accNext};
    end
  end

endmodule

// File: heapController.sv
/*
  Request controller: accepts one request, checks the array is live,
  starts the allocator, store or search and holds the response
*/
`timescale 1ns/1ps
`include "heap_consts.svh"

module heapController import heapOpsPkg::*, heapCtrlPkg::*; (
  input  logic                        clock,
  input  logic                        resetN,
  input  logic                        reqValid,
  output logic                        reqReady,
  input  heapOp                       reqOp,
  input  logic [`HEAP_ADDR_BITS-1:0]  reqArray,
  input  logic [`HEAP_INDEX_BITS-1:0] reqIndex,
  input  logic [`HEAP_DATA_BITS-1:0]  reqData,
  output logic                        respValid,
  input  logic                        respReady,
  output logic [`HEAP_DATA_BITS-1:0]  respData,
  output heapStatus                   respStatus,
  output logic                        allocStart,
  output logic                        freeStart,
  output logic                        clearStart,
  output logic [`HEAP_ADDR_BITS-1:0]  lookupArray,
  input  logic                        arrayLive,
  input  logic [`HEAP_ADDR_BITS-1:0]  newArray,
  input  logic                        allocOk,
  output logic                        storeStart,
  output heapOp                       storeOp,
  output logic [`HEAP_ADDR_BITS-1:0]  storeArray,
  output logic [`HEAP_INDEX_BITS-1:0] storeIndex,
  output logic [`HEAP_DATA_BITS-1:0]  storeData,
  input  logic [`HEAP_DATA_BITS-1:0]  storeResult,
  input  heapStatus                   storeStatus,
  output logic                        searchStart,
  output heapOp                       searchOp,
  output logic [`HEAP_ADDR_BITS-1:0]  searchArray,
  output logic [`HEAP_DATA_BITS-1:0]  searchKey,
  input  logic                        searchDone,
  input  logic [`HEAP_DATA_BITS-1:0]  searchResult
);

  ctrlState                    state;
  heapOp                       curOp;
  logic [`HEAP_ADDR_BITS-1:0]  curArray;
  logic [`HEAP_INDEX_BITS-1:0] curIndex;
  logic [`HEAP_DATA_BITS-1:0]  curData;
  logic                        useStore;           // Answer comes from the store
  logic [`HEAP_DATA_BITS-1:0]  heldData;
  heapStatus                   heldStatus;
  logic                        execUseStore;
  logic [`HEAP_DATA_BITS-1:0]  execData;
  heapStatus                   execStatus;

  assign reqReady    = (state == ctrlIdle);
  assign respValid   = (state == ctrlRespond);
  assign respData    = useStore ? storeResult : heldData;
  assign respStatus  = useStore ? storeStatus : heldStatus;
  assign lookupArray = curArray;
  assign storeOp     = curOp;
  assign storeIndex  = curIndex;
  assign storeData   = curData;
  assign searchOp    = curOp;
  assign searchArray = curArray;
  assign searchKey   = curData;

  // --------------------
  // Dispatch in ctrlExec
  always_comb begin
    allocStart   = 1'b0;
    freeStart    = 1'b0;
    clearStart   = 1'b0;
    storeStart   = 1'b0;
    searchStart  = 1'b0;
    storeArray   = curArray;
    execUseStore = 1'b0;
    execData     = '0;
    execStatus   = statusOk;
    if (state == ctrlExec) begin
      case (curOp)
        opClear: clearStart = 1'b1;
        opAlloc: begin
          allocStart = 1'b1;
          storeStart = allocOk;                     // Store empties the new array
          storeArray = newArray;
          if (allocOk) execData = {{(`HEAP_DATA_BITS - `HEAP_ADDR_BITS){1'b0}}, newArray};
          else execStatus = statusOutOfMemory;
        end
        default: begin
          if (!arrayLive) begin
            execStatus = statusNotAllocated;
          end else if (curOp == opFree) begin
            freeStart = 1'b1;
          end else if (curOp inside {opIndex, opLess, opGreater}) begin
            searchStart = 1'b1;
          end else begin
            storeStart   = 1'b1;
            execUseStore = 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state <= ctrlIdle;
    end else begin
      case (state)
        ctrlIdle:    if (reqValid) state <= ctrlExec;
        ctrlExec:    state <= searchStart ? ctrlScan : ctrlRespond;
        ctrlScan:    if (searchDone) state <= ctrlRespond;
        ctrlRespond: if (respReady) state <= ctrlIdle;
        default:     state <= ctrlIdle;
      endcase
    end
  end

  // Request fields and response hold
  always_ff @(posedge clock) begin
    if (state == ctrlIdle && reqValid) begin
      curOp    <= reqOp;
      curArray <= reqArray;
      curIndex <= reqIndex;
      curData  <= reqData;
    end
    if (state == ctrlExec) begin
      useStore   <= execUseStore;
      heldData   <= execData;
      heldStatus <= execStatus;
    end
    if (state == ctrlScan && searchDone) begin
      heldData   <= searchResult;
      heldStatus <= statusOk;
    end
  end

endmodule

// File: heapTop.sv
/*
  Array heap top level: controller, allocator, store and search unit
*/
`timescale 1ns/1ps
`include "heap_consts.svh"

module heapTop import heapOpsPkg::*; (
  input  logic                        clock,
  input  logic                        resetN,
  input  logic                        reqValid,
  output logic                        reqReady,
  input  heapOp                       reqOp,
  input  logic [`HEAP_ADDR_BITS-1:0]  reqArray,
  input  logic [`HEAP_INDEX_BITS-1:0] reqIndex,
  input  logic [`HEAP_DATA_BITS-1:0]  reqData,
  output logic                        respValid,
  input  logic                        respReady,
  output logic [`HEAP_DATA_BITS-1:0]  respData,
  output heapStatus                   respStatus
);

  logic                        allocStart, freeStart, clearStart;
  logic [`HEAP_ADDR_BITS-1:0]  lookupArray, newArray;
  logic                        arrayLive, allocOk;
  logic                        storeStart;
  heapOp                       storeOp, searchOp;
  logic [`HEAP_ADDR_BITS-1:0]  storeArray, searchArray, scanArray;
  logic [`HEAP_INDEX_BITS-1:0] storeIndex, scanIndex;
  logic [`HEAP_DATA_BITS-1:0]  storeData, storeResult, scanElement;
  heapStatus                   storeStatus;
  logic [`HEAP_SIZE_BITS-1:0]  scanSize;
  logic                        searchStart, searchDone;
  logic [`HEAP_DATA_BITS-1:0]  searchKey, searchResult;

  heapController ctrl_i (
    .clock, .resetN,
    .reqValid, .reqReady, .reqOp, .reqArray, .reqIndex, .reqData,
    .respValid, .respReady, .respData, .respStatus,
    .allocStart, .freeStart, .clearStart, .lookupArray,
    .arrayLive, .newArray, .allocOk,
    .storeStart, .storeOp, .storeArray, .storeIndex, .storeData,
    .storeResult, .storeStatus,
    .searchStart, .searchOp, .searchArray, .searchKey,
    .searchDone, .searchResult
  );

  heapAllocator alloc_i (
    .clock, .resetN,
    .allocStart, .freeStart, .clearStart, .lookupArray,
    .arrayLive, .newArray, .allocOk
  );

  heapStore store_i (
    .clock, .resetN,
    .storeStart, .storeOp, .storeArray, .storeIndex, .storeData,
    .storeResult, .storeStatus,
    .scanArray, .scanIndex, .scanElement, .scanSize
  );

  heapSearch search_i (
    .clock, .resetN,
    .searchStart, .searchOp, .searchArray, .searchKey,
    .scanArray, .scanIndex, .scanElement, .scanSize,
    .searchDone, .searchResult
  );

endmodule

// File: heap_assert.sv
/*
  Handshake assertions on the heap top level, bound into heapTop
*/
`timescale 1ns/1ps
`include "heap_consts.svh"

module heapAssert import heapOpsPkg::*; (
  input logic                       clock,
  input logic                       resetN,
  input logic                       reqReady,
  input logic                       respValid,
  input logic                       respReady,
  input logic [`HEAP_DATA_BITS-1:0] respData,
  input heapStatus                  respStatus
);

  // Response held until consumed
  property respHeld;
    @(posedge clock) disable iff (!resetN)
      respValid && !respReady |=> respValid && $stable(respData) && $stable(respStatus);
  endproperty

  // One request in flight
  property noReqDuringResp;
    @(posedge clock) disable iff (!resetN)
      respValid |-> !reqReady;
  endproperty

  property quietAfterReset;
    @(posedge clock) $rose(resetN) |-> !respValid;
  endproperty

  holdCheck:  assert property (respHeld) else $error("response changed before it was consumed");
  readyCheck: assert property (noReqDuringResp) else $error("reqReady high during a response");
  resetCheck: assert property (quietAfterReset) else $error("respValid high right after reset");

endmodule

bind heapTop heapAssert assert_i (
  .clock(clock),
  .resetN(resetN),
  .reqReady(reqReady),
  .respValid(respValid),
  .respReady(respReady),
  .respData(respData),
  .respStatus(respStatus)
);

// File: heapTb.sv
/*
  Heap testbench: clock and reset, requests read from heap_tests.txt,
  random response back-pressure, checks and a closing summary
*/
`timescale 1ns/1ps
`include "heap_consts.svh"

module heapTb import heapOpsPkg::*; ();

  logic                        clock;
  logic                        resetN;
  logic                        reqValid;
  logic                        reqReady;
  heapOp                       reqOp;
  logic [`HEAP_ADDR_BITS-1:0]  reqArray;
  logic [`HEAP_INDEX_BITS-1:0] reqIndex;
  logic [`HEAP_DATA_BITS-1:0]  reqData;
  logic                        respValid;
  logic                        respReady;
  logic [`HEAP_DATA_BITS-1:0]  respData;
  heapStatus                   respStatus;

  logic [31:0] testOp [$];
  logic [31:0] testArray [$];
  logic [31:0] testIndex [$];
  logic [31:0] testData [$];
  logic [31:0] wantData [$];
  logic [31:0] wantStatus [$];

  int     numTests;
  int     errorCount = 0;
  int     passCount = 0;
  int     cycleLimit = 0;      // Zero until the tests are loaded
  int     cycles = 0;
  integer seed = 32'h8d64_fa9c;

  heapTop heapTop_i (
    .clock, .resetN,
    .reqValid, .reqReady, .reqOp, .reqArray, .reqIndex, .reqData,
    .respValid, .respReady, .respData, .respStatus
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // --------------------
  // Helpers
  task automatic loadTests();
    int          fd;
    int          got;
    string       line;
    logic [31:0] f0, f1, f2, f3, f4, f5;
    fd = $fopen("heap_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open heap_tests.txt for reading");
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) > 0) begin
          got = $sscanf(line, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5);
          if (got == 6) begin                  // Comment and blank lines skipped
            testOp.push_back(f0);
            testArray.push_back(f1);
            testIndex.push_back(f2);
            testData.push_back(f3);
            wantData.push_back(f4);
            wantStatus.push_back(f5);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic checkValue(input logic [31:0] got, input logic [31:0] want,
                            input string what);
    if (got !== want) begin
      $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, want);
      errorCount++;
    end
  endtask

  // Starts and ends on a falling edge
  task automatic runRequest(input int idx);
    int          errorsBefore;
    logic [31:0] rnd;
    bit          taken;
    errorsBefore = errorCount;
    respReady = 1'b0;                          // A stray response stays up
    checkValue(32'(respValid), 32'd0, $sformatf("test %0d respValid before request", idx));
    reqOp    = heapOp'(testOp[idx][3:0]);
    reqArray = testArray[idx][`HEAP_ADDR_BITS-1:0];
    reqIndex = testIndex[idx][`HEAP_INDEX_BITS-1:0];
    reqData  = testData[idx][`HEAP_DATA_BITS-1:0];
    reqValid = 1'b1;
    while (!reqReady) @(negedge clock);        // Taken on the next rising edge
    @(negedge clock);
    reqValid = 1'b0;
    taken = 1'b0;
    while (!taken) begin
      rnd = $random(seed);
      respReady = rnd[0];                      // Random back-pressure
      if (respValid && respReady) begin
        checkValue(32'(respData), wantData[idx], $sformatf("test %0d data", idx));
        checkValue(32'(respStatus), wantStatus[idx], $sformatf("test %0d status", idx));
        taken = 1'b1;
      end
      @(negedge clock);
    end
    if (errorCount == errorsBefore) begin
      passCount++;
      $display("test %0d %s ok", idx, reqOp.name());
    end else begin
      $display("test %0d %s FAILED", idx, reqOp.name());
    end
  endtask

  // --------------------
  // Main sequence
  initial begin
    resetN    = 1'b0;
    reqValid  = 1'b0;
    reqOp     = opClear;
    reqArray  = '0;
    reqIndex  = '0;
    reqData   = '0;
    respReady = 1'b0;
    loadTests();
    numTests   = testOp.size();
    cycleLimit = numTests * 40;
    if (numTests == 0) begin
      $display("no requests found in heap_tests.txt");
      $display("sim failed");
      $finish;
    end else begin
      repeat (2) @(negedge clock);
      resetN = 1'b1;
      for (int i = 0; i < numTests; i++) begin
        runRequest(i);
      end
      respReady = 1'b0;                        // A duplicate response would stay up
      repeat (3) @(negedge clock);
      checkValue(32'(respValid), 32'd0, "respValid after the last test");
      $display("%0d tests, %0d passed, %0d failed", numTests, passCount,
               numTests - passCount);
      if (errorCount == 0) begin
        $display("sim passed");
      end else begin
        $display("sim failed");
      end
      $finish;
    end
  end

  // Watchdog
  initial begin
    wait (cycleLimit > 0);
    while (cycles < cycleLimit) begin
      @(posedge clock);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d clock cycles", cycleLimit);
    $display("sim failed");
    $finish;
  end

endmodule

// File: heap_tests.txt
// op array index data expData expStatus, all hex, one request per line
// op 0 clr 1 alloc 2 free 3 wr 4 rd 5 size 6 push 7 pop 8 resize 9 index A less B greater
0 0 0 000 000 0
1 0 0 000 000 0
1 0 0 000 001 0
1 0 0 000 002 0
1 0 0 000 003 0
1 0 0 000 000 5   // pool used up
2 1 0 000 000 0
2 2 0 000 000 0
1 0 0 000 002 0   // freed arrays come back last first
1 0 0 000 001 0
2 1 0 000 000 0
2 1 0 000 000 1   // already freed
0 0 0 000 000 0
1 0 0 000 000 0
3 0 0 064 064 0
3 0 1 0c8 0c8 0
3 0 2 12c 12c 0
5 0 0 000 003 0
4 0 3 000 000 2
4 0 1 000 0c8 0
4 1 0 000 000 1
3 2 0 005 000 1
1 0 0 000 001 0
6 1 0 00a 00a 0
6 1 0 014 014 0
6 1 0 01e 01e 0
6 1 0 028 028 0
6 1 0 032 000 3
7 1 0 000 028 0
7 1 0 000 01e 0
7 1 0 000 014 0
7 1 0 000 00a 0
7 1 0 000 000 4
8 1 0 005 000 6
8 1 0 003 003 0
5 1 0 000 003 0
1 0 0 000 002 0
6 2 0 00a 00a 0
6 2 0 014 014 0
6 2 0 01e 01e 0
9 2 0 01e 003 0
9 2 0 014 002 0
9 2 0 00a 001 0
9 2 0 00f 000 0
a 2 0 023 003 0
a 2 0 019 002 0
a 2 0 00f 001 0
a 2 0 005 000 0
b 2 0 023 000 0
b 2 0 019 001 0
b 2 0 00f 002 0
b 2 0 005 003 0
9 1 0 028 000 0   // element past the size is ignored
a 3 0 005 000 1

// File: project.f
+incdir+.
heapOpsPkg.sv
heapCtrlPkg.sv
heapAllocator.sv
heapStore.sv
heapSearch.sv
heapController.sv
heapTop.sv
heap_assert.sv
heapTb.sv

// File: run.sh
#!/bin/sh
# Build the heap testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module heapTb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/VheapTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
  exit 0
fi
exit 1
